//--- design/ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
  input  ex_pkg::ex_in_t ex_in_i,
  output ex_pkg::word_t  alu_result_o
);

  import ex_pkg::*;

  alu_op_t    alu_op;
  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;

  // ============================================================
  // Operation decode
  // ============================================================

  always_comb begin
    alu_op = ADD;
    if (ex_in_i.alu_instr == ALU_INSTR_FUNCT) begin
      case (ex_in_i.funct3)
        // SUB only exists in the register-register form
        3'b000: alu_op = (ex_in_i.op_b5 && ex_in_i.funct7_b5) ? SUB : ADD;
        3'b001: alu_op = SLL;
        3'b010: alu_op = SLT;
        3'b011: alu_op = SLTU;
        3'b100: alu_op = XOR;
        // Shift type from funct7 bit, valid for SRAI too
        3'b101: alu_op = ex_in_i.funct7_b5 ? SRA : SRL;
        3'b110: alu_op = OR;
        default: alu_op = AND;
      endcase
    end
  end

  // ============================================================
  // Operand selection
  // ============================================================

  always_comb begin
    case (ex_in_i.alu_a_src)
      ALU_A_ZERO: op_a = '0;
      ALU_A_PC:   op_a = ex_in_i.pc;
      default:    op_a = ex_in_i.rs1_data;
    endcase
  end

  assign op_b  = (ex_in_i.alu_b_src == ALU_B_IMM) ? ex_in_i.imm : ex_in_i.rs2_data;

  // Shift amount is the low five bits of B
  assign shamt = op_b[4:0];

  // ============================================================
  // Arithmetic and logic
  // ============================================================

  always_comb begin
    case (alu_op)
      SUB:     alu_result_o = op_a - op_b;
      SLL:     alu_result_o = op_a << shamt;
      SLT:     alu_result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      SLTU:    alu_result_o = {{(XLEN-1){1'b0}}, op_a < op_b};
      XOR:     alu_result_o = op_a ^ op_b;
      SRL:     alu_result_o = op_a >> shamt;
      SRA:     alu_result_o = $signed(op_a) >>> shamt;
      OR:      alu_result_o = op_a | op_b;
      AND:     alu_result_o = op_a & op_b;
      default: alu_result_o = op_a + op_b;
    endcase
  end

endmodule

`default_nettype wire

//--- design/ex_branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module ex_branch_unit (
  input  ex_pkg::ex_in_t ex_in_i,
  input  ex_pkg::word_t  alu_result_i,
  input  logic           s_valid_i,
  input  logic           stall_i,
  output logic           branch_taken_o,
  output ex_pkg::word_t  jb_tgt_o,
  output logic           misalign_o,
  output logic           pc_sel_o,
  output ex_pkg::word_t  redir_tgt_o
);

  import ex_pkg::*;

  logic  cmp_eq;
  logic  cmp_lt;
  logic  cmp_ltu;
  logic  cond;
  logic  jb_active;
  word_t tgt_pc_rel;
  word_t tgt_jalr;

  // ============================================================
  // Branch compare
  // ============================================================

  assign cmp_eq  = (ex_in_i.rs1_data == ex_in_i.rs2_data);
  assign cmp_lt  = ($signed(ex_in_i.rs1_data) < $signed(ex_in_i.rs2_data));
  assign cmp_ltu = (ex_in_i.rs1_data < ex_in_i.rs2_data);

  // funct3 bit 0 inverts the base condition
  always_comb begin
    case (ex_in_i.funct3)
      3'b000, 3'b001: cond = cmp_eq ^ ex_in_i.funct3[0];
      3'b100, 3'b101: cond = cmp_lt ^ ex_in_i.funct3[0];
      3'b110, 3'b111: cond = cmp_ltu ^ ex_in_i.funct3[0];
      default:        cond = 1'b0;
    endcase
  end

  assign branch_taken_o = ex_in_i.is_branch & cond;

  // ============================================================
  // Target and redirect
  // ============================================================

  // Branches and JAL use a dedicated adder
  assign tgt_pc_rel = ex_in_i.pc + ex_in_i.imm;
  // JALR is rs1 + imm from the ALU with bit 0 cleared
  assign tgt_jalr   = {alu_result_i[XLEN-1:1], 1'b0};
  assign jb_tgt_o   = ex_in_i.jb_tgt_src ? tgt_jalr : tgt_pc_rel;

  assign jb_active  = branch_taken_o | ex_in_i.is_jal | ex_in_i.is_jalr;
  // Targets must be word aligned without compressed support
  assign misalign_o = jb_active & (|jb_tgt_o[1:0]);

  // Redirect only when EX actually takes the instruction
  assign pc_sel_o    = jb_active & s_valid_i & ~stall_i;
  assign redir_tgt_o = jb_tgt_o;

endmodule

`default_nettype wire

//--- design/ex_divider.sv
`timescale 1ns/100ps
`default_nettype none

module ex_divider #(
  parameter int DIV_STEPS = 1
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start_i,
  input  ex_pkg::word_t   dividend_i,
  input  ex_pkg::word_t   divisor_i,
  input  ex_pkg::funct3_t funct3_i,
  output logic            busy_o,
  output ex_pkg::word_t   result_o
);

  import ex_pkg::*;

  localparam int DIV_CYCLES = XLEN / DIV_STEPS;
  localparam int CNT_W      = $clog2(DIV_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  word_t            quo_q;
  word_t            rem_q;
  word_t            dvs_q;
  logic             quo_neg_q;
  logic             rem_neg_q;
  logic             is_rem_q;

  logic             is_signed;
  logic             a_neg;
  logic             b_neg;
  word_t            a_mag;
  word_t            b_mag;
  word_t            quo_nxt;
  word_t            rem_nxt;
  logic [XLEN:0]    diff;

  // ============================================================
  // Operand magnitudes
  // ============================================================

  // DIV and REM are signed, DIVU and REMU are not
  assign is_signed = ~funct3_i[0];
  assign a_neg     = is_signed & dividend_i[XLEN-1];
  assign b_neg     = is_signed & divisor_i[XLEN-1];
  assign a_mag     = a_neg ? -dividend_i : dividend_i;
  assign b_mag     = b_neg ? -divisor_i : divisor_i;

  // ============================================================
  // Restoring steps, DIV_STEPS quotient bits per clock
  // ============================================================

  always_comb begin
    quo_nxt = quo_q;
    rem_nxt = rem_q;
    diff    = '0;
    for (int i = 0; i < DIV_STEPS; i++) begin
      // Shift next dividend bit into remainder and trial subtract
      diff = {rem_nxt, quo_nxt[XLEN-1]} - {1'b0, dvs_q};
      if (diff[XLEN]) begin
        // Negative, restore
        rem_nxt = {rem_nxt[XLEN-2:0], quo_nxt[XLEN-1]};
        quo_nxt = {quo_nxt[XLEN-2:0], 1'b0};
      end else begin
        rem_nxt = diff[XLEN-1:0];
        quo_nxt = {quo_nxt[XLEN-2:0], 1'b1};
      end
    end
  end

  // Step counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_W'(DIV_CYCLES);
    end else if (busy_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign busy_o = (cnt_q != '0);

  // Quotient register starts as dividend and fills from the bottom
  always_ff @(posedge clk) begin
    if (start_i) begin
      quo_q     <= a_mag;
      rem_q     <= '0;
      dvs_q     <= b_mag;
      // Zero divisor yields all ones, so never negate the quotient
      quo_neg_q <= (a_neg ^ b_neg) & (divisor_i != '0);
      // Remainder takes the dividend sign, also for zero divisor
      rem_neg_q <= a_neg;
      is_rem_q  <= funct3_i[1];
    end else if (busy_o) begin
      quo_q <= quo_nxt;
      rem_q <= rem_nxt;
    end
  end

  // Sign fixup, MIN / -1 falls out as MIN with remainder 0
  assign result_o = is_rem_q ? (rem_neg_q ? -rem_q : rem_q)
                             : (quo_neg_q ? -quo_q : quo_q);

endmodule

`default_nettype wire

//--- design/ex_mem_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex_mem_reg (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall_i,
  input  logic                    valid_i,
  input  logic                    flush_i,
  input  ex_pkg::ex_mem_ctrl_t    ctrl_i,
  input  ex_pkg::ex_mem_payload_t payload_i,
  output logic                    valid_o,
  output ex_pkg::ex_mem_ctrl_t    ctrl_o,
  output ex_pkg::ex_mem_payload_t payload_o
);

  logic bubble;

  // Flush and empty slots both turn into a bubble
  assign bubble = flush_i | ~valid_i;

  // ============================================================
  // Control half
  // ============================================================

  // Downstream uses these without rechecking valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
      ctrl_o  <= '0;
    end else if (!stall_i) begin
      if (bubble) begin
        valid_o <= 1'b0;
        ctrl_o  <= '0;
      end else begin
        valid_o <= 1'b1;
        ctrl_o  <= ctrl_i;
      end
    end
  end

  // ============================================================
  // Payload half
  // ============================================================

  // Loaded every advance, only meaningful with valid_o
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      payload_o <= payload_i;
    end
  end

endmodule

`default_nettype wire

//--- design/ex_pkg.sv
`default_nettype none

package ex_pkg;

  // Datapath width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [2:0] funct3_t;

  // ALU operand A source
  typedef enum logic [1:0] {
    ALU_A_RS1,
    ALU_A_ZERO,
    ALU_A_PC
  } alu_a_src_t;

  // ALU operand B source
  typedef enum logic {
    ALU_B_RS2,
    ALU_B_IMM
  } alu_b_src_t;

  // Force add, or decode from funct fields
  typedef enum logic [1:0] {
    ALU_INSTR_ADD,
    ALU_INSTR_FUNCT
  } alu_instr_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } alu_op_t;

  typedef enum logic [1:0] {
    TRAP_NONE,
    TRAP_ILLEGAL,
    TRAP_INSTR_MISALIGN,
    TRAP_ECALL
  } trap_code_t;

  // Sequencer for multi-cycle ops
  typedef enum logic [1:0] {
    EX_IDLE,
    EX_MC_EXEC,
    EX_MC_DONE
  } ex_state_t;

  // Decoded instruction from ID
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    alu_a_src_t alu_a_src;
    alu_b_src_t alu_b_src;
    alu_instr_t alu_instr;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    // 0 pc relative, 1 register
    logic       jb_tgt_src;
    logic       is_div;
    logic       trap;
    trap_code_t trap_code;
    funct3_t    funct3;
    logic       funct7_b5;
    logic       op_b5;
    reg_addr_t  rd;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    word_t      pc;
  } ex_in_t;

  // Control half of EX/MEM, cleared on bubble
  typedef struct packed {
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic trap;
  } ex_mem_ctrl_t;

  // Payload half of EX/MEM, may hold stale data
  typedef struct packed {
    reg_addr_t  rd;
    funct3_t    funct3;
    word_t      alu_result;
    word_t      rs2_data;
    word_t      pc_plus4;
    word_t      jb_tgt;
    word_t      m_result;
    logic       branch_taken;
    trap_code_t trap_code;
  } ex_mem_payload_t;

endpackage

`default_nettype wire

//--- design/ex_seq_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module ex_seq_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic s_valid_i,
  input  logic is_div_i,
  input  logic stall_i,
  input  logic flush_i,
  input  logic div_busy_i,
  input  logic m_valid_i,
  output logic div_start_o,
  output logic op_active_o,
  output logic pipe_valid_o,
  output logic pipe_flush_o
);

  import ex_pkg::*;

  ex_state_t state_q;
  ex_state_t state_nxt;
  logic      start;

  // ============================================================
  // Next state and output valid
  // ============================================================

  always_comb begin
    state_nxt    = state_q;
    pipe_valid_o = 1'b0;
    op_active_o  = 1'b0;
    start        = 1'b0;
    case (state_q)
      EX_IDLE: begin
        if (s_valid_i) begin
          if (is_div_i) begin
            state_nxt   = EX_MC_EXEC;
            start       = 1'b1;
            op_active_o = 1'b1;
          end else begin
            pipe_valid_o = 1'b1;
          end
        end
      end
      EX_MC_EXEC: begin
        op_active_o = 1'b1;
        // Divider done, release ID and push the result
        if (!div_busy_i) begin
          op_active_o  = 1'b0;
          state_nxt    = EX_MC_DONE;
          pipe_valid_o = 1'b1;
        end
      end
      EX_MC_DONE: begin
        // Result is in EX/MEM, take the next instruction
        if (m_valid_i) begin
          if (s_valid_i && is_div_i) begin
            state_nxt   = EX_MC_EXEC;
            start       = 1'b1;
            op_active_o = 1'b1;
          end else begin
            state_nxt    = EX_IDLE;
            pipe_valid_o = s_valid_i;
          end
        end
      end
      default: begin
        state_nxt = EX_IDLE;
      end
    endcase
  end

  // Launch only on an accepting edge
  assign div_start_o = start & ~stall_i;

  // Frozen while stalled so a finished divide is not lost
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= EX_IDLE;
    end else if (!stall_i) begin
      state_q <= state_nxt;
    end
  end

  // Hold back a flush that arrives mid divide
  assign pipe_flush_o = flush_i & ~(op_active_o | (state_q == EX_MC_EXEC));

endmodule

`default_nettype wire

//--- design/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage #(
  parameter int DIV_STEPS = 1
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    s_valid_i,
  input  logic                    stall_i,
  input  logic                    flush_i,
  input  ex_pkg::ex_in_t          ex_in_i,
  output logic                    m_valid_o,
  output ex_pkg::ex_mem_ctrl_t    ctrl_o,
  output ex_pkg::ex_mem_payload_t payload_o,
  output logic                    op_active_o,
  output logic                    pc_sel_o,
  output ex_pkg::word_t           redir_tgt_o
);

  import ex_pkg::*;

  word_t           alu_result;
  word_t           jb_tgt;
  word_t           m_result;
  word_t           pc_plus4;
  logic            branch_taken;
  logic            misalign;
  logic            div_start;
  logic            div_busy;
  logic            pipe_valid;
  logic            pipe_flush;
  ex_mem_ctrl_t    ctrl_d;
  ex_mem_payload_t payload_d;

  // ============================================================
  // Execute units
  // ============================================================

  ex_alu u_alu (
    .ex_in_i      (ex_in_i),
    .alu_result_o (alu_result)
  );

  ex_branch_unit u_branch (
    .ex_in_i        (ex_in_i),
    .alu_result_i   (alu_result),
    .s_valid_i      (s_valid_i),
    .stall_i        (stall_i),
    .branch_taken_o (branch_taken),
    .jb_tgt_o       (jb_tgt),
    .misalign_o     (misalign),
    .pc_sel_o       (pc_sel_o),
    .redir_tgt_o    (redir_tgt_o)
  );

  ex_divider #(
    .DIV_STEPS (DIV_STEPS)
  ) u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (div_start),
    .dividend_i (ex_in_i.rs1_data),
    .divisor_i  (ex_in_i.rs2_data),
    .funct3_i   (ex_in_i.funct3),
    .busy_o     (div_busy),
    .result_o   (m_result)
  );

  ex_seq_ctrl u_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_valid_i    (s_valid_i),
    .is_div_i     (ex_in_i.is_div),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .div_busy_i   (div_busy),
    .m_valid_i    (m_valid_o),
    .div_start_o  (div_start),
    .op_active_o  (op_active_o),
    .pipe_valid_o (pipe_valid),
    .pipe_flush_o (pipe_flush)
  );

  // ============================================================
  // EX/MEM assembly
  // ============================================================

  assign pc_plus4 = ex_in_i.pc + word_t'(4);

  // Misaligned target raises a trap on top of any ID trap
  assign ctrl_d.reg_write = ex_in_i.reg_write;
  assign ctrl_d.mem_read  = ex_in_i.mem_read;
  assign ctrl_d.mem_write = ex_in_i.mem_write;
  assign ctrl_d.trap      = ex_in_i.trap | misalign;

  assign payload_d.rd           = ex_in_i.rd;
  assign payload_d.funct3       = ex_in_i.funct3;
  assign payload_d.alu_result   = alu_result;
  assign payload_d.rs2_data     = ex_in_i.rs2_data;
  assign payload_d.pc_plus4     = pc_plus4;
  assign payload_d.jb_tgt       = jb_tgt;
  assign payload_d.m_result     = m_result;
  assign payload_d.branch_taken = branch_taken;
  assign payload_d.trap_code    = misalign ? TRAP_INSTR_MISALIGN : ex_in_i.trap_code;

  ex_mem_reg u_pipe (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall_i   (stall_i),
    .valid_i   (pipe_valid),
    .flush_i   (pipe_flush),
    .ctrl_i    (ctrl_d),
    .payload_i (payload_d),
    .valid_o   (m_valid_o),
    .ctrl_o    (ctrl_o),
    .payload_o (payload_o)
  );

endmodule

`default_nettype wire

//--- dv/ex_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage_tb;

  import ex_pkg::*;

  localparam int DIV_STEPS  = 1;
  localparam int TB_OPS     = 300;
  localparam int RST_CYCLES = 10;
  // Worst case is every op a divide plus a few stalled edges
  localparam int MAX_CYCLES = TB_OPS * (XLEN + 4) + RST_CYCLES;

  // Expected EX/MEM entry plus what to compare
  typedef struct packed {
    logic         is_div;
    logic         jb;
    ex_mem_ctrl_t ctrl;
    reg_addr_t    rd;
    funct3_t      funct3;
    word_t        alu_result;
    word_t        rs2_data;
    word_t        pc_plus4;
    word_t        jb_tgt;
    word_t        m_result;
    logic         branch_taken;
    trap_code_t   trap_code;
  } exp_t;

  logic            clk;
  logic            rst_n;
  logic            s_valid_i;
  logic            stall_i;
  logic            flush_i;
  ex_in_t          ex_in_i;
  logic            m_valid_o;
  ex_mem_ctrl_t    ctrl_o;
  ex_mem_payload_t payload_o;
  logic            op_active_o;
  logic            pc_sel_o;
  word_t           redir_tgt_o;

  exp_t            exp_q[$];
  int              mismatches = 0;
  int              failures   = 0;
  int              cycles     = 0;
  logic            running;
  logic            advanced;
  logic            last_valid;
  ex_mem_ctrl_t    last_ctrl;
  ex_mem_payload_t last_payload;

  ex_stage #(
    .DIV_STEPS (DIV_STEPS)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_valid_i   (s_valid_i),
    .stall_i     (stall_i),
    .flush_i     (flush_i),
    .ex_in_i     (ex_in_i),
    .m_valid_o   (m_valid_o),
    .ctrl_o      (ctrl_o),
    .payload_o   (payload_o),
    .op_active_o (op_active_o),
    .pc_sel_o    (pc_sel_o),
    .redir_tgt_o (redir_tgt_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ============================================================
  // Helpers
  // ============================================================

  function automatic logic chance(int pct);
    return $urandom_range(99) < pct;
  endfunction

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  // RISC-V divide rules incl. zero divisor and signed overflow
  function automatic word_t riscv_divide(funct3_t f3, word_t a, word_t b);
    word_t q;
    word_t r;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (!f3[0] && a == 32'h8000_0000 && b == '1) begin
      q = a;
      r = '0;
    end else if (!f3[0]) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return f3[1] ? r : q;
  endfunction

  // Reference model of one EX instruction
  function automatic exp_t ref_execute(ex_in_t in);
    word_t a;
    word_t b;
    word_t alu;
    word_t tgt;
    logic  taken;
    logic  mis;
    exp_t  e;
    case (in.alu_a_src)
      ALU_A_ZERO: a = '0;
      ALU_A_PC:   a = in.pc;
      default:    a = in.rs1_data;
    endcase
    b = (in.alu_b_src == ALU_B_IMM) ? in.imm : in.rs2_data;
    if (in.alu_instr == ALU_INSTR_ADD) begin
      alu = a + b;
    end else begin
      case (in.funct3)
        3'd0: alu = (in.op_b5 && in.funct7_b5) ? a - b : a + b;
        3'd1: alu = a << b[4:0];
        3'd2: alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: alu = (a < b) ? 32'd1 : 32'd0;
        3'd4: alu = a ^ b;
        3'd5: alu = in.funct7_b5 ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: alu = a | b;
        default: alu = a & b;
      endcase
    end
    case (in.funct3)
      3'd0: taken = (in.rs1_data == in.rs2_data);
      3'd1: taken = (in.rs1_data != in.rs2_data);
      3'd4: taken = ($signed(in.rs1_data) < $signed(in.rs2_data));
      3'd5: taken = ($signed(in.rs1_data) >= $signed(in.rs2_data));
      3'd6: taken = (in.rs1_data < in.rs2_data);
      3'd7: taken = (in.rs1_data >= in.rs2_data);
      default: taken = 1'b0;
    endcase
    taken = taken & in.is_branch;
    tgt   = in.jb_tgt_src ? {alu[XLEN-1:1], 1'b0} : in.pc + in.imm;
    e.jb  = taken | in.is_jal | in.is_jalr;
    mis   = e.jb & (tgt[1:0] != 2'b00);
    e.is_div         = in.is_div;
    e.ctrl.reg_write = in.reg_write;
    e.ctrl.mem_read  = in.mem_read;
    e.ctrl.mem_write = in.mem_write;
    e.ctrl.trap      = in.trap | mis;
    e.rd             = in.rd;
    e.funct3         = in.funct3;
    e.alu_result     = alu;
    e.rs2_data       = in.rs2_data;
    e.pc_plus4       = in.pc + 32'd4;
    e.jb_tgt         = tgt;
    e.m_result       = riscv_divide(in.funct3, in.rs1_data, in.rs2_data);
    e.branch_taken   = taken;
    e.trap_code      = mis ? TRAP_INSTR_MISALIGN : in.trap_code;
    return e;
  endfunction

  // Random ALU, branch/jump or divide instruction
  function automatic ex_in_t random_instr();
    ex_in_t in;
    int     sel;
    in           = '0;
    in.rs1_data  = $urandom;
    in.rs2_data  = $urandom;
    in.imm       = $urandom;
    in.pc        = $urandom & 32'hffff_fffc;
    in.rd        = reg_addr_t'($urandom);
    in.reg_write = 1'b1;
    in.trap      = chance(5);
    in.trap_code = in.trap ? TRAP_ECALL : TRAP_NONE;
    case ($urandom_range(2))
      0: begin
        in.alu_instr = alu_instr_t'($urandom_range(1));
        in.alu_a_src = alu_a_src_t'($urandom_range(2));
        in.alu_b_src = alu_b_src_t'($urandom_range(1));
        in.funct3    = funct3_t'($urandom_range(7));
        in.funct7_b5 = chance(50);
        in.op_b5     = (in.alu_b_src == ALU_B_RS2);
        in.mem_read  = chance(15);
        in.mem_write = !in.mem_read && chance(15);
      end
      1: begin
        // Word aligned offset that is sometimes off by two
        in.imm = ($urandom & 32'h0000_0ffc) ^ (chance(50) ? 32'hffff_f000 : 32'h0);
        in.imm = in.imm | (chance(25) ? 32'd2 : 32'd0);
        sel    = $urandom_range(3);
        if (sel < 2) begin
          in.is_branch = 1'b1;
          in.reg_write = 1'b0;
          sel          = $urandom_range(5);
          in.funct3    = funct3_t'(sel < 2 ? sel : sel + 2);
          if (chance(30)) begin
            in.rs2_data = in.rs1_data;
          end
        end else if (sel == 2) begin
          in.is_jal = 1'b1;
        end else begin
          // JALR goes through the ALU as rs1 + imm
          in.is_jalr    = 1'b1;
          in.jb_tgt_src = 1'b1;
          in.alu_b_src  = ALU_B_IMM;
          if (chance(70)) begin
            in.rs1_data = in.rs1_data & 32'hffff_fffc;
          end
        end
      end
      default: begin
        in.is_div    = 1'b1;
        in.alu_instr = ALU_INSTR_FUNCT;
        in.op_b5     = 1'b1;
        in.funct3    = funct3_t'(3'b100 | 3'($urandom_range(3)));
        sel          = $urandom_range(4);
        if (sel == 0) begin
          in.rs2_data = '0;
        end else if (sel == 1) begin
          in.rs1_data = 32'h8000_0000;
          in.rs2_data = '1;
        end else if (sel == 2) begin
          in.rs1_data = word_t'($urandom_range(200)) - 32'd100;
          in.rs2_data = word_t'($urandom_range(20)) - 32'd10;
        end
      end
    endcase
    return in;
  endfunction

  // ============================================================
  // Stimulus
  // ============================================================

  initial begin : stimulus
    ex_in_t cur;
    exp_t   e;
    logic   have;
    logic   cur_stall;
    logic   cur_flush;
    logic   op_act;
    logic   exp_sel;
    int     phase;
    int     busy_cnt;
    int     sent;
    int     tail;
    void'($urandom(32'h87670967));
    rst_n     = 1'b0;
    s_valid_i = 1'b0;
    stall_i   = 1'b0;
    flush_i   = 1'b0;
    ex_in_i   = '0;
    running   = 1'b0;
    advanced  = 1'b0;
    cur       = '0;
    have      = 1'b0;
    cur_stall = 1'b0;
    cur_flush = 1'b0;
    op_act    = 1'b0;
    phase     = 0;
    busy_cnt  = 0;
    sent      = 0;
    tail      = 0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("m_valid_o", 64'(m_valid_o), 64'd0);
    check_value("ctrl_o", 64'(ctrl_o), 64'd0);
    check_value("op_active_o", 64'(op_active_o), 64'd0);
    check_value("pc_sel_o", 64'(pc_sel_o), 64'd0);
    while (tail < 4) begin
      @(posedge clk);
      // Register loads on every edge without stall
      advanced = !cur_stall;
      running  = 1'b1;
      if (have && !cur_stall) begin
        e = ref_execute(cur);
        if (!cur.is_div) begin
          // Flush kills a single-cycle op at its accepting edge
          if (!cur_flush) begin
            exp_q.push_back(e);
          end
          have = 1'b0;
          sent++;
        end else if (phase == 0) begin
          phase    = 1;
          busy_cnt = 0;
        end else if (!op_act) begin
          if (busy_cnt != XLEN / DIV_STEPS) begin
            failures++;
            $display("Divide was active for %0d cycles", busy_cnt);
          end
          exp_q.push_back(e);
          have  = 1'b0;
          phase = 0;
          sent++;
        end
      end
      if (sent >= TB_OPS) begin
        tail++;
      end else if (!have && chance(75)) begin
        cur  = random_instr();
        have = 1'b1;
      end
      cur_stall = chance(20);
      cur_flush = chance(10);
      s_valid_i <= have;
      ex_in_i   <= cur;
      stall_i   <= cur_stall;
      flush_i   <= cur_flush;
      @(negedge clk);
      op_act  = op_active_o;
      e       = ref_execute(cur);
      exp_sel = have && !cur_stall && e.jb;
      check_value("pc_sel_o", 64'(pc_sel_o), 64'(exp_sel));
      if (exp_sel) begin
        check_value("redir_tgt_o", 64'(redir_tgt_o), 64'(e.jb_tgt));
      end
      // op_active covers start cycle and every busy cycle
      if (have && cur.is_div && phase == 0) begin
        check_value("op_active_o", 64'(op_act), 64'd1);
      end else if (phase == 1) begin
        if (op_act) begin
          busy_cnt++;
        end
      end else begin
        check_value("op_active_o", 64'(op_act), 64'd0);
      end
    end
    repeat (2) @(negedge clk);
    if (exp_q.size() != 0) begin
      failures++;
      $display("%0d expected results never appeared", exp_q.size());
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // ============================================================
  // Result compare
  // ============================================================

  always @(negedge clk) begin : compare
    exp_t e;
    if (running) begin
      if (advanced) begin
        if (m_valid_o) begin
          if (exp_q.size() == 0) begin
            failures++;
            $display("Result appeared with nothing expected");
          end else begin
            e = exp_q.pop_front();
            check_value("ctrl_o", 64'(ctrl_o), 64'(e.ctrl));
            check_value("rd", 64'(payload_o.rd), 64'(e.rd));
            check_value("funct3", 64'(payload_o.funct3), 64'(e.funct3));
            check_value("alu_result", 64'(payload_o.alu_result), 64'(e.alu_result));
            check_value("rs2_data", 64'(payload_o.rs2_data), 64'(e.rs2_data));
            check_value("pc_plus4", 64'(payload_o.pc_plus4), 64'(e.pc_plus4));
            check_value("branch_taken", 64'(payload_o.branch_taken), 64'(e.branch_taken));
            check_value("trap_code", 64'(payload_o.trap_code), 64'(e.trap_code));
            if (e.jb) begin
              check_value("jb_tgt", 64'(payload_o.jb_tgt), 64'(e.jb_tgt));
            end
            if (e.is_div) begin
              check_value("m_result", 64'(payload_o.m_result), 64'(e.m_result));
            end
          end
        end else begin
          check_value("ctrl_o", 64'(ctrl_o), 64'd0);
        end
      end else begin
        // Stalled edge holds everything
        check_value("m_valid_o", 64'(m_valid_o), 64'(last_valid));
        check_value("ctrl_o", 64'(ctrl_o), 64'(last_ctrl));
        if (payload_o !== last_payload) begin
          mismatches++;
          $display("MISMATCH payload_o: got %h expected %h", payload_o, last_payload);
        end
      end
    end
    last_valid   = m_valid_o;
    last_ctrl    = ctrl_o;
    last_payload = payload_o;
  end

  // Cycle limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results pending", cycles, exp_q.size());
      $display("CHECKS FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- files.f
design/ex_pkg.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_divider.sv
design/ex_seq_ctrl.sv
design/ex_mem_reg.sv
design/ex_stage.sv
dv/ex_stage_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f files.f --top-module ex_stage_tb -o ex_stage_tb_sim &&
./obj_dir/ex_stage_tb_sim | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
